//--- design/pt_walk_defs.svh
/* Address, line, entry and table geometry macros for the page-table walker */

`ifndef PT_WALK_DEFS_SVH
`define PT_WALK_DEFS_SVH

// Byte address widths
`define PT_VA_BITS          48
`define PT_PA_BITS          48

// 4 KB pages and the page numbers left above the offset
`define PT_PAGE_OFFSET_BITS 12
`define PT_VA_PAGE_BITS     (`PT_VA_BITS - `PT_PAGE_OFFSET_BITS)
`define PT_PA_PAGE_BITS     (`PT_PA_BITS - `PT_PAGE_OFFSET_BITS)

// 64-byte memory lines
`define PT_LINE_OFFSET_BITS 6
`define PT_CL_ADDR_BITS     (`PT_PA_BITS - `PT_LINE_OFFSET_BITS)
`define PT_LINE_BITS        512
`define PT_WORD_BITS        64

// Table geometry: 512 entries per table page, 8 entries per line
`define PT_IDX_BITS         9
`define PT_MAX_DEPTH        4
`define PT_WORD_IDX_BITS    3
`define PT_LINE_IDX_BITS    (`PT_IDX_BITS - `PT_WORD_IDX_BITS)

// Status bits in the low end of an entry
`define PT_TERMINAL_BIT     0
`define PT_ERROR_BIT        1

`endif

//--- design/pt_addr_pkg.sv
/* Address format types: page numbers, line addresses, lines and entry words */

`include "pt_walk_defs.svh"

package pt_addr_pkg;

    // Virtual page number of a 4 KB page
    typedef logic [`PT_VA_PAGE_BITS-1:0] va_page_t;

    // Physical page number
    // Also the page field of a table entry, entry bits 47..12
    typedef logic [`PT_PA_PAGE_BITS-1:0] pa_page_t;

    // Line address of a memory read
    typedef logic [`PT_CL_ADDR_BITS-1:0] cl_addr_t;

    // One full response line
    typedef logic [`PT_LINE_BITS-1:0] cl_data_t;

    // One table entry
    typedef logic [`PT_WORD_BITS-1:0] pt_word_t;

endpackage

//--- design/pt_walk_pkg.sv
/* Walk control types: table indices, walk depth and walker FSM states */

`include "pt_walk_defs.svh"

package pt_walk_pkg;

    // Index of one entry in a table page, taken from the VA
    typedef logic [`PT_IDX_BITS-1:0] pt_idx_t;

    // Upper part of a level index picks the line in the table page
    typedef logic [`PT_LINE_IDX_BITS-1:0] pt_line_idx_t;

    // Lower part picks the entry word in that line
    typedef logic [`PT_WORD_IDX_BITS-1:0] pt_word_idx_t;

    // Current level, 0 is the root
    typedef logic [$clog2(`PT_MAX_DEPTH)-1:0] walk_depth_t;

    // Walker FSM
    typedef enum logic [2:0]
    {
        walk_idle,
        walk_read_req,
        walk_wait_rsp,
        walk_step,
        walk_done,
        walk_error
    } walk_state_t;

endpackage

//--- design/pt_va_index.sv
/* VA level index tracker; current level always sits in the top slot */

`timescale 1ns/1ps
`include "pt_walk_defs.svh"

module pt_va_index
(
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      load,
    input  logic                      advance,
    input  pt_addr_pkg::va_page_t     va,
    output pt_walk_pkg::pt_line_idx_t line_idx,
    output pt_walk_pkg::pt_word_idx_t word_idx
);

    // Four 9-bit indices, root level in the top slot
    pt_walk_pkg::pt_idx_t [`PT_MAX_DEPTH-1:0] idx_vec;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            idx_vec <= '0;
        end
        else if (load)
        begin
            // VA page bits 35..27 land in the top slot for the root
            idx_vec <= va;
        end
        else if (advance)
        begin
            // Shift up one level, zero fill behind
            idx_vec <= {idx_vec[`PT_MAX_DEPTH-2:0], pt_walk_pkg::pt_idx_t'(0)};
        end
    end

    // Line in the table page, then word in the line
    assign {line_idx, word_idx} = idx_vec[`PT_MAX_DEPTH-1];

endmodule

//--- design/pt_entry_capture.sv
/* Response line register, entry word selection and entry decode */

`timescale 1ns/1ps
`include "pt_walk_defs.svh"

module pt_entry_capture
(
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      read_data_en,
    input  pt_addr_pkg::cl_data_t     read_data,
    input  pt_walk_pkg::pt_word_idx_t word_idx,
    output logic                      entry_valid,
    output logic                      entry_terminal,
    output logic                      entry_error,
    output pt_addr_pkg::pa_page_t     entry_page
);

    // Strobe pipeline, two stages
    logic data_en_q;
    logic data_en_qq;

    // Registered line, then the one word needed from it
    pt_addr_pkg::cl_data_t data_q;
    pt_addr_pkg::pt_word_t word_qq;

    pt_addr_pkg::pt_word_t word_sel;

    // Entry for the current level out of the registered line
    assign word_sel = data_q[word_idx * `PT_WORD_BITS +: `PT_WORD_BITS];

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            data_en_q  <= 1'b0;
            data_en_qq <= 1'b0;
        end
        else
        begin
            data_en_q  <= read_data_en;
            data_en_qq <= data_en_q;
        end
    end

    // Held until the next response so the FSM can read it in its step state
    always_ff @(posedge clk)
    begin
        if (read_data_en)
        begin
            data_q <= read_data;
        end

        if (data_en_q)
        begin
            word_qq <= word_sel;
        end
    end

    // ========================================================================
    // Entry decode
    // ========================================================================

    assign entry_valid    = data_en_qq;
    assign entry_terminal = word_qq[`PT_TERMINAL_BIT];

    // Software fills unused entries with all ones, so bit 1 flags them
    assign entry_error    = word_qq[`PT_ERROR_BIT];
    assign entry_page     = word_qq[`PT_PA_BITS-1:`PT_PAGE_OFFSET_BITS];

endmodule

//--- design/pt_walk_ctrl.sv
/* Walker FSM: request intake, table line reads, level stepping,
   TLB fill and sticky not-present error */

`timescale 1ns/1ps
`include "pt_walk_defs.svh"

module pt_walk_ctrl
(
    input  logic                      clk,
    input  logic                      reset,
    input  pt_addr_pkg::pa_page_t     table_base,
    input  logic                      table_base_valid,
    input  logic                      walk_enable,
    input  logic                      req_en,
    input  pt_addr_pkg::va_page_t     req_va,
    input  logic                      read_rdy,
    input  logic                      fill_rdy,
    input  pt_walk_pkg::pt_line_idx_t line_idx,
    input  logic                      entry_valid,
    input  logic                      entry_terminal,
    input  logic                      entry_error,
    input  pt_addr_pkg::pa_page_t     entry_page,
    output logic                      req_rdy,
    output logic                      read_en,
    output pt_addr_pkg::cl_addr_t     read_addr,
    output logic                      fill_en,
    output pt_addr_pkg::va_page_t     fill_va,
    output pt_addr_pkg::pa_page_t     fill_pa,
    output logic                      fill_big_page,
    output logic                      not_present,
    output logic                      index_load,
    output logic                      index_advance
);

    pt_walk_pkg::walk_state_t state;

    // Flag copies of the idle and done states, kept off the state decode
    logic idle_flag;
    logic done_flag;

    // Set once software has a valid table base and has enabled walks
    logic initialized;

    // VA being translated
    pt_addr_pkg::va_page_t walk_va;

    // Table page being read; holds the translated page once done
    pt_addr_pkg::pa_page_t cur_page;

    pt_walk_pkg::walk_depth_t depth;

    logic req_take;
    logic last_level;
    logic step_fail;

    // ========================================================================
    // Step decisions
    // ========================================================================

    assign req_take   = req_en && req_rdy;
    assign last_level = (depth == pt_walk_pkg::walk_depth_t'(`PT_MAX_DEPTH - 1));

    // Bad entry, or still pointing down at the deepest level
    assign step_fail  = entry_error || (!entry_terminal && last_level);

    assign index_load    = req_take;
    assign index_advance = (state == pt_walk_pkg::walk_step) && !entry_terminal && !step_fail;

    // ========================================================================
    // FSM
    // ========================================================================

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            state       <= pt_walk_pkg::walk_idle;
            idle_flag   <= 1'b1;
            done_flag   <= 1'b0;
            initialized <= 1'b0;
            not_present <= 1'b0;
            depth       <= '0;
        end
        else
        begin
            initialized <= table_base_valid && walk_enable;

            case (state)
                pt_walk_pkg::walk_idle:
                begin
                    // Every walk starts at the root
                    if (req_take)
                    begin
                        state     <= pt_walk_pkg::walk_read_req;
                        idle_flag <= 1'b0;
                        depth     <= '0;
                    end
                end

                pt_walk_pkg::walk_read_req:
                begin
                    if (read_en)
                    begin
                        state <= pt_walk_pkg::walk_wait_rsp;
                    end
                end

                pt_walk_pkg::walk_wait_rsp:
                begin
                    if (entry_valid)
                    begin
                        state <= pt_walk_pkg::walk_step;
                    end
                end

                pt_walk_pkg::walk_step:
                begin
                    if (step_fail)
                    begin
                        state       <= pt_walk_pkg::walk_error;
                        not_present <= 1'b1;
                    end
                    else if (entry_terminal)
                    begin
                        state     <= pt_walk_pkg::walk_done;
                        done_flag <= 1'b1;
                    end
                    else
                    begin
                        // Next level down
                        state <= pt_walk_pkg::walk_read_req;
                        depth <= depth + pt_walk_pkg::walk_depth_t'(1);
                    end
                end

                pt_walk_pkg::walk_done:
                begin
                    if (fill_en)
                    begin
                        state     <= pt_walk_pkg::walk_idle;
                        idle_flag <= 1'b1;
                        done_flag <= 1'b0;
                    end
                end

                // Stuck here until reset
                pt_walk_pkg::walk_error:
                begin
                    not_present <= 1'b1;
                end

                default:
                begin
                    state <= pt_walk_pkg::walk_error;
                end
            endcase
        end
    end

    // Walk payload, loaded at acceptance and updated per step
    always_ff @(posedge clk)
    begin
        if (req_take)
        begin
            walk_va  <= req_va;
            cur_page <= table_base;
        end
        else if (state == pt_walk_pkg::walk_step)
        begin
            cur_page <= entry_page;
        end
    end

    // ========================================================================
    // Outputs
    // ========================================================================

    // One walk at a time
    assign req_rdy = initialized && idle_flag;

    // Line address: table page, then the line index of this level
    assign read_en   = (state == pt_walk_pkg::walk_read_req) && read_rdy;
    assign read_addr = {cur_page, line_idx};

    assign fill_en = done_flag && fill_rdy;
    assign fill_va = walk_va;
    assign fill_pa = cur_page;

    // Terminal at depth 2 is a 2 MB page, at depth 3 a 4 KB page
    assign fill_big_page = !depth[0];

endmodule

//--- design/pt_walk.sv
/* Page-table walker top level: controller, VA index tracker and entry capture */

`timescale 1ns/1ps

module pt_walk
(
    input  logic                  clk,
    input  logic                  reset,

    // Software setup
    input  pt_addr_pkg::pa_page_t table_base,
    input  logic                  table_base_valid,
    input  logic                  walk_enable,

    // Miss requests from the TLB
    output logic                  req_rdy,
    input  logic                  req_en,
    input  pt_addr_pkg::va_page_t req_va,

    // Table line reads
    input  logic                  read_rdy,
    output logic                  read_en,
    output pt_addr_pkg::cl_addr_t read_addr,
    input  logic                  read_data_en,
    input  pt_addr_pkg::cl_data_t read_data,

    // TLB fill
    input  logic                  fill_rdy,
    output logic                  fill_en,
    output pt_addr_pkg::va_page_t fill_va,
    output pt_addr_pkg::pa_page_t fill_pa,
    output logic                  fill_big_page,

    // Sticky walk failure
    output logic                  not_present
);

    // Controller to index tracker
    logic                      index_load;
    logic                      index_advance;

    // Current level index, split for the read address and the word pick
    pt_walk_pkg::pt_line_idx_t line_idx;
    pt_walk_pkg::pt_word_idx_t word_idx;

    // Decoded entry back to the controller
    logic                      entry_valid;
    logic                      entry_terminal;
    logic                      entry_error;
    pt_addr_pkg::pa_page_t     entry_page;

    pt_walk_ctrl ctrl_inst
    (
        .clk              (clk),
        .reset            (reset),
        .table_base       (table_base),
        .table_base_valid (table_base_valid),
        .walk_enable      (walk_enable),
        .req_en           (req_en),
        .req_va           (req_va),
        .read_rdy         (read_rdy),
        .fill_rdy         (fill_rdy),
        .line_idx         (line_idx),
        .entry_valid      (entry_valid),
        .entry_terminal   (entry_terminal),
        .entry_error      (entry_error),
        .entry_page       (entry_page),
        .req_rdy          (req_rdy),
        .read_en          (read_en),
        .read_addr        (read_addr),
        .fill_en          (fill_en),
        .fill_va          (fill_va),
        .fill_pa          (fill_pa),
        .fill_big_page    (fill_big_page),
        .not_present      (not_present),
        .index_load       (index_load),
        .index_advance    (index_advance)
    );

    pt_va_index va_index_inst
    (
        .clk      (clk),
        .reset    (reset),
        .load     (index_load),
        .advance  (index_advance),
        .va       (req_va),
        .line_idx (line_idx),
        .word_idx (word_idx)
    );

    pt_entry_capture entry_capture_inst
    (
        .clk            (clk),
        .reset          (reset),
        .read_data_en   (read_data_en),
        .read_data      (read_data),
        .word_idx       (word_idx),
        .entry_valid    (entry_valid),
        .entry_terminal (entry_terminal),
        .entry_error    (entry_error),
        .entry_page     (entry_page)
    );

endmodule

//--- tests/pt_walk_tb.sv
/* Page-table walker testbench: clock, reset, LFSR, memory model with
   table builder, assertions and result reporting */

`timescale 1ns/1ps
`include "pt_walk_defs.svh"

module pt_walk_tb;

    localparam int TIMEOUT = 2000;
    localparam logic [15:0] SEED = 16'd59787;

    // Physical pages that hold the tables
    localparam pt_addr_pkg::pa_page_t ROOT_PAGE = 36'h0_0001_0000;
    localparam pt_addr_pkg::pa_page_t L1_PAGE   = 36'h0_0002_0100;
    localparam pt_addr_pkg::pa_page_t L2_PAGE   = 36'h0_0003_0200;
    localparam pt_addr_pkg::pa_page_t L3_PAGE   = 36'h0_0004_0300;

    logic clk = 1'b0;
    logic reset;
    pt_addr_pkg::pa_page_t table_base;
    logic table_base_valid;
    logic walk_enable;
    logic req_rdy;
    logic req_en;
    pt_addr_pkg::va_page_t req_va;
    logic read_rdy;
    logic read_en;
    pt_addr_pkg::cl_addr_t read_addr;
    logic read_data_en;
    pt_addr_pkg::cl_data_t read_data;
    logic fill_rdy;
    logic fill_en;
    pt_addr_pkg::va_page_t fill_va;
    pt_addr_pkg::pa_page_t fill_pa;
    logic fill_big_page;
    logic not_present;

    // Memory model and scoreboard state
    pt_addr_pkg::cl_data_t mem [pt_addr_pkg::cl_addr_t];
    pt_addr_pkg::cl_addr_t exp_addr[$];
    pt_addr_pkg::cl_addr_t rsp_addr[$];
    int rsp_due[$];
    logic [15:0] lfsr = SEED;
    int cycle = 0;
    int errors = 0;
    int tests_run = 0;
    int tests_failed = 0;
    int read_count;
    bit fill_seen;
    bit expect_fill;
    bit busy = 0;
    bit rand_mode = 0;
    pt_addr_pkg::va_page_t exp_va;
    pt_addr_pkg::pa_page_t exp_pa;
    logic exp_big;

    pt_walk pt_walk_inst (.*);

    always #4 clk = ~clk;

    // ========================================================================
    // Helpers
    // ========================================================================

    // Taps 16,14,13,11
    function logic lfsr_bit();
        logic fb;
        fb = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
        lfsr = {lfsr[14:0], fb};
        return fb;
    endfunction

    function logic [63:0] rand_bits(input int n);
        logic [63:0] v;
        v = '0;
        for (int i = 0; i < n; i++)
            v = {v[62:0], lfsr_bit()};
        return v;
    endfunction

    // Unwritten lines carry their own address and have the error bit set
    function pt_addr_pkg::cl_data_t blank_line(input pt_addr_pkg::cl_addr_t la);
        pt_addr_pkg::cl_data_t l;
        for (int w = 0; w < 8; w++)
            l[w*64 +: 64] = {la, 3'(w), 19'h7ffff};
        return l;
    endfunction

    function pt_addr_pkg::pt_word_t make_entry(input pt_addr_pkg::pa_page_t pg,
                                               input logic term, input logic err);
        return {16'h0, pg, 10'h0, err, term};
    endfunction

    // Depth 0 takes VA page bits 35..27
    function pt_walk_pkg::pt_idx_t level_idx(input pt_addr_pkg::va_page_t va, input int d);
        return va[35 - 9*d -: 9];
    endfunction

    task automatic write_entry(input pt_addr_pkg::pa_page_t pg, input pt_walk_pkg::pt_idx_t ix,
                               input pt_addr_pkg::pt_word_t e);
        pt_addr_pkg::cl_addr_t la;
        pt_addr_pkg::cl_data_t l;
        la = {pg, ix[8:3]};
        l = mem.exists(la) ? mem[la] : blank_line(la);
        l[ix[2:0]*64 +: 64] = e;
        mem[la] = l;
    endtask

    task automatic stop_on_timeout(input string what);
        $display("timeout while waiting for %s", what);
        $display("TEST RESULT: FAIL");
        $finish;
    endtask

    task automatic apply_reset();
        reset = 1'b1;
        repeat (2) @(negedge clk);
        reset = 1'b0;
    endtask

    task automatic finish_test(input string name, input int err_before);
        tests_run++;
        if (errors != err_before)
            tests_failed++;
        $display("test %0d %s: %s", tests_run, name, (errors == err_before) ? "ok" : "failed");
    endtask

    // ========================================================================
    // Memory, monitors and assertions
    // ========================================================================

    always @(posedge clk)
    begin
        cycle++;
        if (reset)
            busy = 0;
        else
        begin
            // Handshake outputs only with their ready
            assert (!read_en || read_rdy) else
            begin
                $display("read_en high while read_rdy was low at %0t", $time);
                errors++;
            end
            assert (!fill_en || fill_rdy) else
            begin
                $display("fill_en high while fill_rdy was low at %0t", $time);
                errors++;
            end
            if (read_en)
            begin
                read_count++;
                rsp_addr.push_back(read_addr);
                rsp_due.push_back(cycle + 1 + int'(rand_bits(3)));
                assert (exp_addr.size() != 0) else
                begin
                    $display("read issued with no read expected at %0t", $time);
                    errors++;
                end
                if (exp_addr.size() != 0)
                begin
                    assert (read_addr == exp_addr[0]) else
                    begin
                        $display("mismatch at %0t: read_addr expected %h actual %h",
                                 $time, exp_addr[0], read_addr);
                        errors++;
                    end
                    void'(exp_addr.pop_front());
                end
            end
            assert (!(busy && req_rdy)) else
            begin
                $display("req_rdy high during a walk at %0t", $time);
                errors++;
            end
            if (req_en && req_rdy)
                busy = 1;
            if (fill_en)
            begin
                busy = 0;
                fill_seen = 1;
                assert (expect_fill) else
                begin
                    $display("unexpected fill at %0t", $time);
                    errors++;
                end
                assert (fill_va == exp_va) else
                begin
                    $display("mismatch at %0t: fill_va expected %h actual %h",
                             $time, exp_va, fill_va);
                    errors++;
                end
                assert (fill_pa == exp_pa) else
                begin
                    $display("mismatch at %0t: fill_pa expected %h actual %h",
                             $time, exp_pa, fill_pa);
                    errors++;
                end
                assert (fill_big_page == exp_big) else
                begin
                    $display("mismatch at %0t: fill_big_page expected %b actual %b",
                             $time, exp_big, fill_big_page);
                    errors++;
                end
            end
        end
    end

    // Responses in order after their delay, plus ready gaps in random mode
    always @(negedge clk)
    begin
        read_data_en = 1'b0;
        if (rsp_addr.size() != 0 && cycle >= rsp_due[0])
        begin
            read_data = mem.exists(rsp_addr[0]) ? mem[rsp_addr[0]] : blank_line(rsp_addr[0]);
            read_data_en = 1'b1;
            void'(rsp_addr.pop_front());
            void'(rsp_due.pop_front());
        end
        read_rdy = rand_mode ? (lfsr_bit() | lfsr_bit()) : 1'b1;
        fill_rdy = rand_mode ? (lfsr_bit() | lfsr_bit()) : 1'b1;
    end

    // Read address held while the walker waits on read_rdy
    assert property (@(posedge clk) disable iff (reset)
        (pt_walk_inst.ctrl_inst.state == pt_walk_pkg::walk_read_req && !read_rdy)
        |=> $stable(read_addr))
    else
    begin
        $display("read_addr changed while read_rdy was low at %0t", $time);
        errors++;
    end

    // Fill outputs held while the TLB holds off
    assert property (@(posedge clk) disable iff (reset)
        (pt_walk_inst.ctrl_inst.done_flag && !fill_rdy)
        |=> ($stable(fill_va) && $stable(fill_pa) && $stable(fill_big_page)))
    else
    begin
        $display("fill outputs changed while fill_rdy was low at %0t", $time);
        errors++;
    end

    // ========================================================================
    // One walk: build tables, send the miss, wait for its end
    // ========================================================================

    // kind 0 ends in a fill, 1 hits an error entry, 2 has no terminal entry
    task automatic run_walk(input pt_addr_pkg::va_page_t va, input int leaf_depth,
                            input int kind, input pt_addr_pkg::pa_page_t leaf, input bit noisy);
        pt_addr_pkg::pa_page_t pages [4];
        pt_walk_pkg::pt_idx_t ix;
        pt_addr_pkg::pt_word_t e;
        int n_reads;
        int t;
        pages = '{ROOT_PAGE, L1_PAGE, L2_PAGE, L3_PAGE};
        mem.delete();
        exp_addr.delete();
        read_count = 0;
        fill_seen = 0;
        n_reads = (kind == 2) ? `PT_MAX_DEPTH : leaf_depth + 1;
        for (int d = 0; d < n_reads; d++)
        begin
            ix = level_idx(va, d);
            exp_addr.push_back({pages[d], ix[8:3]});
            if (d < n_reads - 1)
                e = make_entry(pages[d + 1], 1'b0, 1'b0);
            else if (kind == 0)
                e = make_entry(leaf, 1'b1, 1'b0);
            else if (kind == 1)
                e = make_entry(L1_PAGE, 1'b0, 1'b1);
            else
                e = make_entry(leaf, 1'b0, 1'b0);
            write_entry(pages[d], ix, e);
        end
        expect_fill = (kind == 0);
        exp_va = va;
        exp_pa = leaf;
        exp_big = (leaf_depth % 2 == 0);

        @(negedge clk);
        req_en = 1'b1;
        req_va = va;
        t = 0;
        while (!req_rdy)
        begin
            @(negedge clk);
            t++;
            if (t > TIMEOUT)
                stop_on_timeout("req_rdy");
        end
        @(negedge clk);
        req_en = 1'b0;

        // Stray requests stop before the last read so none lands after the fill
        t = 0;
        while ((kind == 0) ? !fill_seen : !not_present)
        begin
            @(negedge clk);
            req_en = noisy && read_count < n_reads && lfsr_bit();
            req_va = pt_addr_pkg::va_page_t'(rand_bits(36));
            t++;
            if (t > TIMEOUT)
                stop_on_timeout(kind == 0 ? "fill_en" : "not_present");
        end
        req_en = 1'b0;
        if (kind != 0)
        begin
            for (int i = 0; i < 10; i++)
                @(negedge clk);
            // Error stays up until the next reset
            assert (not_present) else
            begin
                $display("not_present fell before reset at %0t", $time);
                errors++;
            end
        end
        assert (read_count == n_reads) else
        begin
            $display("mismatch at %0t: read count expected %0d actual %0d",
                     $time, n_reads, read_count);
            errors++;
        end
    endtask

    // ========================================================================
    // Test sequence
    // ========================================================================

    initial
    begin
        int e0;
        reset = 1'b1;
        table_base = ROOT_PAGE;
        table_base_valid = 1'b0;
        walk_enable = 1'b0;
        req_en = 1'b0;
        req_va = '0;
        read_rdy = 1'b1;
        read_data_en = 1'b0;
        read_data = '0;
        fill_rdy = 1'b1;
        apply_reset();

        e0 = errors;
        assert (!req_rdy && !read_en && !fill_en && !not_present) else
        begin
            $display("outputs not low after reset at %0t", $time);
            errors++;
        end
        table_base_valid = 1'b1;
        for (int i = 0; i < 4; i++)
        begin
            @(negedge clk);
            assert (!req_rdy) else
            begin
                $display("req_rdy high before walk_enable at %0t", $time);
                errors++;
            end
        end
        walk_enable = 1'b1;
        finish_test("reset and enable", e0);

        e0 = errors;
        run_walk(36'h1_2345_6789, 3, 0, 36'h0_00AB_C123, 0);
        finish_test("4 KB walk", e0);

        e0 = errors;
        run_walk(36'h9_8765_4321, 2, 0, 36'h0_0012_3000, 0);
        finish_test("2 MB walk", e0);

        e0 = errors;
        rand_mode = 1;
        for (int i = 0; i < 6; i++)
            run_walk(pt_addr_pkg::va_page_t'(rand_bits(36)), 3, 0,
                     pt_addr_pkg::pa_page_t'(rand_bits(36)), 1);
        rand_mode = 0;
        finish_test("random back-pressure", e0);

        e0 = errors;
        run_walk(36'h5_5555_AAAA, 1, 1, '0, 0);
        finish_test("error entry", e0);

        e0 = errors;
        apply_reset();
        run_walk(36'hA_BCDE_F012, 3, 2, 36'h0_0077_7000, 0);
        finish_test("no terminal entry", e0);

        $display("tests %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0)
            $display("TEST RESULT: PASS");
        else
            $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule

//--- verilog.f
+incdir+design
design/pt_addr_pkg.sv
design/pt_walk_pkg.sv
design/pt_va_index.sv
design/pt_entry_capture.sv
design/pt_walk_ctrl.sv
design/pt_walk.sv
tests/pt_walk_tb.sv

//--- Makefile
# Verilator build and run for the page-table walker

VERILATOR  ?= verilator
TOP        ?= pt_walk_tb
RTL_TOP    ?= pt_walk
FILELIST   ?= verilog.f
OBJ_DIR    ?= obj_dir
VFLAGS     ?= --binary --timing --assert -j 0
LINT_FLAGS ?= --lint-only --timing -Wall
PASS_MSG   ?= TEST RESULT: PASS

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(OBJ_DIR)
